/* filelist.f */
+incdir+include
source/cpu_control_pkg.sv
source/control_if.sv
source/subcycle_timer.sv
source/instruction_register.sv
source/control_decoder.sv
source/control_unit.sv
verification/clock_gen.sv
verification/control_unit_tb.sv

/* source/control_decoder.sv */
module control_decoder (
    input  cpu_control_pkg::subcycle_t cycle,
    input  logic [7:0]                 inst,
    input  logic                       two_word,
    input  logic                       take_branch,
    input  logic                       reg_is_zero,
    output logic                       two_word_next,
    output logic                       operand_adj,
    control_if.decoder                 ctrl
);
    import cpu_control_pkg::*;

    opcode_e opcode;
    acc_op_e acc_op;
    logic    jump_taken;
    logic    alu_to_acc;

    assign opcode = opcode_e'(inst[7:4]);
    assign acc_op = acc_op_e'(inst[3:0]);

    // Jump condition for the second word
    always_comb begin
        case (opcode)
            OP_JCN:  jump_taken = take_branch;
            OP_ISZ:  jump_taken = !reg_is_zero;
            default: jump_taken = 1'b1;
        endcase
    end

    always_comb begin
        ctrl.clear_carry       = 1'b0;
        ctrl.write_carry       = 1'b0;
        ctrl.clear_accumulator = 1'b0;
        ctrl.write_accumulator = 1'b0;
        ctrl.acc_input_sel     = ACC_IN_NONE;
        ctrl.write_register    = 1'b0;
        ctrl.reg_input_sel     = REG_IN_NONE;
        ctrl.alu_op            = ALU_OP_ADD;
        ctrl.alu_in0_sel       = ALU_IN0_NONE;
        ctrl.alu_in1_sel       = ALU_IN1_NONE;
        ctrl.alu_cin_sel       = ALU_CIN_ZERO;
        ctrl.pc_next_sel       = PC_NEXT_DATA;
        ctrl.pc_write_enable   = PC_WRITE_NONE;
        ctrl.pc_control        = PC_STACK_NOP;
        alu_to_acc             = 1'b0;
        two_word_next          = two_word;
        operand_adj            = 1'b0;

        if (two_word) begin
            // Second word is on the bus in subcycles 3 and 4
            if (cycle == SC_EXECUTE) begin
                two_word_next = 1'b0;
            end
            case (opcode)
                OP_JCN, OP_JUN, OP_JMS, OP_ISZ: begin
                    if (opcode == OP_JMS && cycle == SC_ROM_CMD) begin
                        ctrl.pc_control = PC_STACK_PUSH;
                    end
                    if (jump_taken && cycle == SC_FETCH_HI) begin
                        ctrl.pc_write_enable = PC_WRITE_HIGH;
                    end else if (jump_taken && cycle == SC_FETCH_LO) begin
                        ctrl.pc_write_enable = PC_WRITE_LOW;
                    end
                end
                OP_FIM: begin
                    if (cycle == SC_FETCH_HI || cycle == SC_FETCH_LO) begin
                        ctrl.reg_input_sel  = REG_IN_DATA;
                        ctrl.write_register = 1'b1;
                        // Low nibble goes to the other register of the pair
                        operand_adj         = (cycle == SC_FETCH_LO);
                    end
                end
                default: begin
                end
            endcase
        end else begin
            case (opcode)
                OP_JCN, OP_FIM, OP_JUN, OP_JMS, OP_ISZ: begin
                    // Odd opcode 2 is SRC and is not decoded
                    if (cycle == SC_EXECUTE && !(opcode == OP_FIM && inst[0])) begin
                        two_word_next = 1'b1;
                    end
                end
                OP_JIN: begin
                    // Low PC half from the second register then the high half from the first
                    if (inst[0] && cycle == SC_EXECUTE) begin
                        ctrl.pc_next_sel     = PC_NEXT_REG;
                        ctrl.pc_write_enable = PC_WRITE_LOW;
                    end else if (inst[0] && cycle == SC_EXECUTE_2) begin
                        ctrl.pc_next_sel     = PC_NEXT_REG;
                        ctrl.pc_write_enable = PC_WRITE_HIGH;
                        operand_adj          = 1'b1;
                    end
                end
                OP_BBL: begin
                    // inst still holds BBL early in the next system cycle
                    if (cycle == SC_ROM_CMD) begin
                        ctrl.pc_control = PC_STACK_POP;
                    end
                end
                default: begin
                end
            endcase

            if (cycle == SC_EXECUTE) begin
                case (opcode)
                    OP_INC, OP_ISZ: begin
                        ctrl.alu_in0_sel    = ALU_IN0_REG;
                        ctrl.alu_in1_sel    = ALU_IN1_ONE;
                        ctrl.reg_input_sel  = REG_IN_ALU;
                        ctrl.write_register = 1'b1;
                    end
                    OP_ADD, OP_SUB: begin
                        ctrl.alu_in0_sel = (opcode == OP_SUB) ? ALU_IN0_REG_INV : ALU_IN0_REG;
                        ctrl.alu_in1_sel = ALU_IN1_ACC;
                        ctrl.alu_cin_sel = (opcode == OP_SUB) ? ALU_CIN_CARRY_INV : ALU_CIN_CARRY;
                        ctrl.write_carry = 1'b1;
                        alu_to_acc       = 1'b1;
                    end
                    OP_LD, OP_XCH: begin
                        ctrl.acc_input_sel     = ACC_IN_REG;
                        ctrl.write_accumulator = 1'b1;
                        if (opcode == OP_XCH) begin
                            ctrl.reg_input_sel  = REG_IN_ACC;
                            ctrl.write_register = 1'b1;
                        end
                    end
                    OP_BBL, OP_LDM: begin
                        ctrl.acc_input_sel     = ACC_IN_IMM;
                        ctrl.write_accumulator = 1'b1;
                    end
                    OP_ACC_GROUP: begin
                        case (acc_op)
                            ACC_CLB: begin
                                ctrl.clear_accumulator = 1'b1;
                                ctrl.clear_carry       = 1'b1;
                            end
                            ACC_CLC: ctrl.clear_carry = 1'b1;
                            ACC_IAC, ACC_DAC: begin
                                // DAC adds 1111 with carry in set
                                ctrl.alu_in0_sel = ALU_IN0_ACC;
                                ctrl.alu_in1_sel = (acc_op == ACC_DAC) ? ALU_IN1_ONE_INV : ALU_IN1_ONE;
                                ctrl.alu_cin_sel = (acc_op == ACC_DAC) ? ALU_CIN_ONE : ALU_CIN_ZERO;
                                ctrl.write_carry = 1'b1;
                                alu_to_acc       = 1'b1;
                            end
                            ACC_CMC, ACC_STC: begin
                                ctrl.alu_cin_sel = (acc_op == ACC_CMC) ? ALU_CIN_CARRY_INV : ALU_CIN_ONE;
                                ctrl.alu_op      = ALU_OP_PASS;
                                ctrl.write_carry = 1'b1;
                            end
                            ACC_CMA: begin
                                ctrl.alu_in0_sel = ALU_IN0_ACC_INV;
                                ctrl.alu_op      = ALU_OP_PASS;
                                alu_to_acc       = 1'b1;
                            end
                            ACC_RAL, ACC_RAR, ACC_DAA: begin
                                ctrl.alu_in0_sel = ALU_IN0_ACC;
                                ctrl.alu_cin_sel = ALU_CIN_CARRY;
                                ctrl.alu_op      = (acc_op == ACC_RAL) ? ALU_OP_ROL :
                                                   (acc_op == ACC_RAR) ? ALU_OP_ROR :
                                                   ALU_OP_DECIMAL_ADJUST;
                                ctrl.write_carry = 1'b1;
                                alu_to_acc       = 1'b1;
                            end
                            ACC_TCC: begin
                                ctrl.acc_input_sel     = ACC_IN_CARRY;
                                ctrl.write_accumulator = 1'b1;
                                ctrl.clear_carry       = 1'b1;
                            end
                            ACC_KBP: begin
                                ctrl.alu_in0_sel = ALU_IN0_ACC;
                                ctrl.alu_op      = ALU_OP_KEYBOARD_CODE;
                                alu_to_acc       = 1'b1;
                            end
                            default: begin
                            end
                        endcase
                    end
                    default: begin
                    end
                endcase
            end
        end

        if (alu_to_acc) begin
            ctrl.acc_input_sel     = ACC_IN_ALU;
            ctrl.write_accumulator = 1'b1;
        end
    end

    // PC writes fall between the second word fetch and the JIN high half
    pc_write_window: assert final (ctrl.pc_write_enable == PC_WRITE_NONE ||
        (cycle >= SC_FETCH_HI && cycle <= SC_EXECUTE_2));

endmodule

/* source/control_if.sv */
interface control_if;
    import cpu_control_pkg::*;

    logic         clear_carry;
    logic         write_carry;
    logic         clear_accumulator;
    logic         write_accumulator;
    acc_in_sel_e  acc_input_sel;
    logic         write_register;
    reg_in_sel_e  reg_input_sel;
    alu_op_e      alu_op;
    alu_in0_sel_e alu_in0_sel;
    alu_in1_sel_e alu_in1_sel;
    alu_cin_sel_e alu_cin_sel;
    pc_next_sel_e pc_next_sel;
    pc_write_e    pc_write_enable;
    pc_stack_e    pc_control;

    modport decoder (
        output clear_carry, write_carry, clear_accumulator, write_accumulator, acc_input_sel,
        output write_register, reg_input_sel, alu_op, alu_in0_sel, alu_in1_sel, alu_cin_sel,
        output pc_next_sel, pc_write_enable, pc_control
    );

    modport datapath (
        input clear_carry, write_carry, clear_accumulator, write_accumulator, acc_input_sel,
        input write_register, reg_input_sel, alu_op, alu_in0_sel, alu_in1_sel, alu_cin_sel,
        input pc_next_sel, pc_write_enable, pc_control
    );

endinterface

/* source/control_unit.sv */
module control_unit (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          halt,
    input  cpu_control_pkg::nibble_t      data,
    input  logic                          take_branch,
    input  logic                          reg_is_zero,
    output logic                          sync,
    output cpu_control_pkg::subcycle_t    cycle,
    output cpu_control_pkg::nibble_t      inst_operand,
    output logic                          rom_cmd,
    output logic                          clear_carry,
    output logic                          write_carry,
    output logic                          clear_accumulator,
    output logic                          write_accumulator,
    output cpu_control_pkg::acc_in_sel_e  acc_input_sel,
    output logic                          write_register,
    output cpu_control_pkg::reg_in_sel_e  reg_input_sel,
    output cpu_control_pkg::alu_op_e      alu_op,
    output cpu_control_pkg::alu_in0_sel_e alu_in0_sel,
    output cpu_control_pkg::alu_in1_sel_e alu_in1_sel,
    output cpu_control_pkg::alu_cin_sel_e alu_cin_sel,
    output cpu_control_pkg::pc_next_sel_e pc_next_sel,
    output cpu_control_pkg::pc_write_e    pc_write_enable,
    output cpu_control_pkg::pc_stack_e    pc_control
);
    logic [7:0] inst;
    logic       two_word;
    logic       two_word_next;
    logic       operand_adj;

    control_if ctrl ();

    subcycle_timer u_timer (
        .clock, .reset, .halt, .cycle, .sync, .rom_cmd
    );

    instruction_register u_inst_reg (
        .clock, .reset, .halt, .two_word_next, .operand_adj, .cycle, .data,
        .inst, .two_word, .inst_operand
    );

    control_decoder u_decoder (
        .cycle, .inst, .two_word, .take_branch, .reg_is_zero,
        .two_word_next, .operand_adj, .ctrl(ctrl.decoder)
    );

    // Control word out to the datapath
    assign clear_carry       = ctrl.clear_carry;
    assign write_carry       = ctrl.write_carry;
    assign clear_accumulator = ctrl.clear_accumulator;
    assign write_accumulator = ctrl.write_accumulator;
    assign acc_input_sel     = ctrl.acc_input_sel;
    assign write_register    = ctrl.write_register;
    assign reg_input_sel     = ctrl.reg_input_sel;
    assign alu_op            = ctrl.alu_op;
    assign alu_in0_sel       = ctrl.alu_in0_sel;
    assign alu_in1_sel       = ctrl.alu_in1_sel;
    assign alu_cin_sel       = ctrl.alu_cin_sel;
    assign pc_next_sel       = ctrl.pc_next_sel;
    assign pc_write_enable   = ctrl.pc_write_enable;
    assign pc_control        = ctrl.pc_control;

endmodule

/* source/cpu_control_pkg.sv */
package cpu_control_pkg;

    typedef logic [3:0] nibble_t;
    typedef logic [2:0] subcycle_t;

    // Subcycles within one system cycle
    localparam subcycle_t SC_ROM_CMD   = 3'd2;
    localparam subcycle_t SC_FETCH_HI  = 3'd3;
    localparam subcycle_t SC_FETCH_LO  = 3'd4;
    localparam subcycle_t SC_EXECUTE   = 3'd5;
    localparam subcycle_t SC_EXECUTE_2 = 3'd6;
    localparam subcycle_t SC_LAST      = 3'd7;

    // High nibble of the instruction
    typedef enum logic [3:0] {
        OP_NOP       = 4'h0,
        OP_JCN       = 4'h1,
        OP_FIM       = 4'h2,
        OP_JIN       = 4'h3,
        OP_JUN       = 4'h4,
        OP_JMS       = 4'h5,
        OP_INC       = 4'h6,
        OP_ISZ       = 4'h7,
        OP_ADD       = 4'h8,
        OP_SUB       = 4'h9,
        OP_LD        = 4'hA,
        OP_XCH       = 4'hB,
        OP_BBL       = 4'hC,
        OP_LDM       = 4'hD,
        OP_IO        = 4'hE,
        OP_ACC_GROUP = 4'hF
    } opcode_e;

    // Low nibble within the accumulator group
    typedef enum logic [3:0] {
        ACC_CLB = 4'h0,
        ACC_CLC = 4'h1,
        ACC_IAC = 4'h2,
        ACC_CMC = 4'h3,
        ACC_CMA = 4'h4,
        ACC_RAL = 4'h5,
        ACC_RAR = 4'h6,
        ACC_TCC = 4'h7,
        ACC_DAC = 4'h8,
        ACC_STC = 4'hA,
        ACC_DAA = 4'hB,
        ACC_KBP = 4'hC
    } acc_op_e;

    typedef enum logic [2:0] {
        ALU_OP_ADD, ALU_OP_PASS, ALU_OP_ROL, ALU_OP_ROR,
        ALU_OP_DECIMAL_ADJUST, ALU_OP_KEYBOARD_CODE
    } alu_op_e;

    typedef enum logic [2:0] {
        ALU_IN0_NONE, ALU_IN0_REG, ALU_IN0_REG_INV, ALU_IN0_ACC,
        ALU_IN0_ACC_INV, ALU_IN0_DATA, ALU_IN0_DATA_INV
    } alu_in0_sel_e;

    typedef enum logic [1:0] {ALU_IN1_NONE, ALU_IN1_ACC, ALU_IN1_ONE, ALU_IN1_ONE_INV} alu_in1_sel_e;
    typedef enum logic [1:0] {ALU_CIN_ZERO, ALU_CIN_ONE, ALU_CIN_CARRY, ALU_CIN_CARRY_INV} alu_cin_sel_e;

    typedef enum logic [2:0] {
        ACC_IN_NONE, ACC_IN_ALU, ACC_IN_REG, ACC_IN_IMM, ACC_IN_DATA, ACC_IN_CARRY
    } acc_in_sel_e;

    typedef enum logic [1:0] {REG_IN_NONE, REG_IN_ALU, REG_IN_ACC, REG_IN_DATA} reg_in_sel_e;
    typedef enum logic {PC_NEXT_DATA, PC_NEXT_REG} pc_next_sel_e;
    // LOW writes pc[3:0] and HIGH writes pc[7:4]
    typedef enum logic [1:0] {PC_WRITE_NONE, PC_WRITE_LOW, PC_WRITE_HIGH} pc_write_e;
    typedef enum logic [1:0] {PC_STACK_NOP, PC_STACK_PUSH, PC_STACK_POP} pc_stack_e;

endpackage

/* source/instruction_register.sv */
module instruction_register (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       halt,
    input  logic                       two_word_next,
    input  logic                       operand_adj,
    input  cpu_control_pkg::subcycle_t cycle,
    input  cpu_control_pkg::nibble_t   data,
    output logic [7:0]                 inst,
    output logic                       two_word,
    output cpu_control_pkg::nibble_t   inst_operand
);
    import cpu_control_pkg::*;

    always_ff @(posedge clock) begin
        if (reset) begin
            inst     <= 8'h00;
            two_word <= 1'b0;
        end else if (!halt) begin
            // A second word goes straight to the decoder and leaves inst alone
            if (!two_word) begin
                if (cycle == SC_FETCH_HI) begin
                    inst[7:4] <= data;
                end else if (cycle == SC_FETCH_LO) begin
                    inst[3:0] <= data;
                end
            end
            two_word <= two_word_next;
        end
    end

    // Flip bit 0 to reach the other register of a pair
    assign inst_operand = inst[3:0] ^ {3'b000, operand_adj};

    // The decoder only starts or ends a second word at the close of subcycle 5
    two_word_at_execute: assert property (
        @(posedge clock) disable iff (reset)
        (two_word != $past(two_word)) |-> ($past(cycle) == SC_EXECUTE)
    );

endmodule

/* source/subcycle_timer.sv */
module subcycle_timer (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       halt,
    output cpu_control_pkg::subcycle_t cycle,
    output logic                       sync,
    output logic                       rom_cmd
);
    import cpu_control_pkg::*;

    // Free running count of subcycles that wraps from 7 to 0
    always_ff @(posedge clock) begin
        if (reset) begin
            cycle <= '0;
        end else if (!halt) begin
            cycle <= cycle + 3'd1;
        end
    end

    // Both strobes are active low
    assign sync    = (cycle != SC_LAST);
    assign rom_cmd = (cycle != SC_ROM_CMD);

    // The low sync pulse marks the last subcycle before a new system cycle
    sync_marks_wrap: assert property (
        @(posedge clock) disable iff (reset)
        (!sync && !halt) |=> (sync && cycle == 3'd0)
    );

endmodule

/* verification/clock_gen.sv */
module clock_gen (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    // Reset spans three rising edges and drops on a falling edge
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

/* include/control_checks.svh */
`ifndef CONTROL_CHECKS_SVH
`define CONTROL_CHECKS_SVH

typedef struct packed {
    logic         clear_carry;
    logic         write_carry;
    logic         clear_accumulator;
    logic         write_accumulator;
    acc_in_sel_e  acc_input_sel;
    logic         write_register;
    reg_in_sel_e  reg_input_sel;
    alu_op_e      alu_op;
    alu_in0_sel_e alu_in0_sel;
    alu_in1_sel_e alu_in1_sel;
    alu_cin_sel_e alu_cin_sel;
    pc_next_sel_e pc_next_sel;
    pc_write_e    pc_write_enable;
    pc_stack_e    pc_control;
} control_word_t;

// JCN, JUN, JMS, ISZ and the even form of opcode 2 take a second word
function automatic logic starts_second_word(input logic [7:0] inst);
    return (inst[7:4] inside {OP_JCN, OP_JUN, OP_JMS, OP_ISZ}) ||
           (inst[7:4] == OP_FIM && !inst[0]);
endfunction

// Low nibble of inst, bit 0 flipped for the other register of a pair
function automatic nibble_t expected_operand(input subcycle_t cycle, input logic [7:0] inst,
        input logic two_word);
    logic flip;
    if (two_word) begin
        flip = (inst[7:4] == OP_FIM) && (cycle == SC_FETCH_LO);
    end else begin
        flip = (inst[7:4] == OP_JIN) && inst[0] && (cycle == SC_EXECUTE_2);
    end
    return {inst[3:1], inst[0] ^ flip};
endfunction

// ALU result into the accumulator
function automatic void to_acc(inout control_word_t c, input alu_in0_sel_e in0,
        input alu_in1_sel_e in1, input alu_cin_sel_e cin, input alu_op_e op, input logic wc);
    c.alu_in0_sel       = in0;
    c.alu_in1_sel       = in1;
    c.alu_cin_sel       = cin;
    c.alu_op            = op;
    c.acc_input_sel     = ACC_IN_ALU;
    c.write_accumulator = 1'b1;
    c.write_carry       = wc;
endfunction

function automatic control_word_t expected_control(input subcycle_t cycle,
        input logic [7:0] inst, input logic two_word, input logic take_branch,
        input logic reg_is_zero);
    control_word_t c;
    logic [3:0]    op;
    logic [3:0]    lo;
    logic          jump;
    c  = '0;
    op = inst[7:4];
    lo = inst[3:0];
    if (two_word) begin
        jump = (op == OP_JCN) ? take_branch : (op == OP_ISZ) ? !reg_is_zero :
               (op inside {OP_JUN, OP_JMS});
        if (jump && cycle inside {SC_FETCH_HI, SC_FETCH_LO}) begin
            c.pc_write_enable = (cycle == SC_FETCH_HI) ? PC_WRITE_HIGH : PC_WRITE_LOW;
        end
        if (op == OP_JMS && cycle == SC_ROM_CMD) begin
            c.pc_control = PC_STACK_PUSH;
        end
        if (op == OP_FIM && cycle inside {SC_FETCH_HI, SC_FETCH_LO}) begin
            c.write_register = 1'b1;
            c.reg_input_sel  = REG_IN_DATA;
        end
        return c;
    end
    if (op == OP_BBL && cycle == SC_ROM_CMD) begin
        c.pc_control = PC_STACK_POP;
    end
    if (op == OP_JIN && lo[0] && cycle inside {SC_EXECUTE, SC_EXECUTE_2}) begin
        c.pc_next_sel     = PC_NEXT_REG;
        c.pc_write_enable = (cycle == SC_EXECUTE) ? PC_WRITE_LOW : PC_WRITE_HIGH;
    end
    if (cycle != SC_EXECUTE) begin
        return c;
    end
    case (op)
        OP_INC, OP_ISZ: begin
            c.alu_in0_sel    = ALU_IN0_REG;
            c.alu_in1_sel    = ALU_IN1_ONE;
            c.reg_input_sel  = REG_IN_ALU;
            c.write_register = 1'b1;
        end
        OP_ADD: to_acc(c, ALU_IN0_REG, ALU_IN1_ACC, ALU_CIN_CARRY, ALU_OP_ADD, 1'b1);
        OP_SUB: to_acc(c, ALU_IN0_REG_INV, ALU_IN1_ACC, ALU_CIN_CARRY_INV, ALU_OP_ADD, 1'b1);
        OP_LD, OP_XCH, OP_BBL, OP_LDM: begin
            c.acc_input_sel     = (op inside {OP_BBL, OP_LDM}) ? ACC_IN_IMM : ACC_IN_REG;
            c.write_accumulator = 1'b1;
            c.write_register    = (op == OP_XCH);
            c.reg_input_sel     = (op == OP_XCH) ? REG_IN_ACC : REG_IN_NONE;
        end
        OP_ACC_GROUP: begin
            case (lo)
                ACC_CLB: begin
                    c.clear_accumulator = 1'b1;
                    c.clear_carry       = 1'b1;
                end
                ACC_CLC: c.clear_carry = 1'b1;
                ACC_IAC: to_acc(c, ALU_IN0_ACC, ALU_IN1_ONE, ALU_CIN_ZERO, ALU_OP_ADD, 1'b1);
                ACC_CMC, ACC_STC: begin
                    c.alu_cin_sel = (lo == ACC_CMC) ? ALU_CIN_CARRY_INV : ALU_CIN_ONE;
                    c.alu_op      = ALU_OP_PASS;
                    c.write_carry = 1'b1;
                end
                ACC_CMA: to_acc(c, ALU_IN0_ACC_INV, ALU_IN1_NONE, ALU_CIN_ZERO, ALU_OP_PASS, 1'b0);
                ACC_RAL: to_acc(c, ALU_IN0_ACC, ALU_IN1_NONE, ALU_CIN_CARRY, ALU_OP_ROL, 1'b1);
                ACC_RAR: to_acc(c, ALU_IN0_ACC, ALU_IN1_NONE, ALU_CIN_CARRY, ALU_OP_ROR, 1'b1);
                ACC_TCC: begin
                    c.acc_input_sel     = ACC_IN_CARRY;
                    c.write_accumulator = 1'b1;
                    c.clear_carry       = 1'b1;
                end
                ACC_DAC: to_acc(c, ALU_IN0_ACC, ALU_IN1_ONE_INV, ALU_CIN_ONE, ALU_OP_ADD, 1'b1);
                ACC_DAA: to_acc(c, ALU_IN0_ACC, ALU_IN1_NONE, ALU_CIN_CARRY,
                                ALU_OP_DECIMAL_ADJUST, 1'b1);
                ACC_KBP: to_acc(c, ALU_IN0_ACC, ALU_IN1_NONE, ALU_CIN_ZERO,
                                ALU_OP_KEYBOARD_CODE, 1'b0);
                default: begin
                end
            endcase
        end
        default: begin
        end
    endcase
    return c;
endfunction

task automatic check_control(input string name, input control_word_t exp,
        input control_word_t got);
    if (got !== exp) begin
        $display("** Error: %s: control word expected %h, actual %h", name, exp, got);
        stop_on_failure();
    end
endtask

task automatic check_subcycle(input string name, input subcycle_t exp_cycle,
        input logic exp_sync, input subcycle_t got_cycle, input logic got_sync);
    if (got_cycle !== exp_cycle || got_sync !== exp_sync) begin
        $display("** Error: %s: expected cycle %0d sync %b, actual cycle %0d sync %b",
                 name, exp_cycle, exp_sync, got_cycle, got_sync);
        stop_on_failure();
    end
endtask

task automatic check_operand(input string name, input nibble_t exp, input nibble_t got);
    if (got !== exp) begin
        $display("** Error: %s: inst_operand expected %h, actual %h", name, exp, got);
        stop_on_failure();
    end
endtask

task automatic check_strobe(input string name, input logic exp_rom_cmd,
        input logic got_rom_cmd);
    if (got_rom_cmd !== exp_rom_cmd) begin
        $display("** Error: %s: rom_cmd expected %b, actual %b", name, exp_rom_cmd,
                 got_rom_cmd);
        stop_on_failure();
    end
endtask

`endif

/* verification/control_unit_tb.sv */
module control_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_control_pkg::*;

    localparam int NUM_SINGLE = 40;
    localparam int NUM_JUMPS  = 4;
    localparam int NUM_COND   = 6;
    localparam int NUM_JIN    = 4;
    localparam int NUM_FIM    = 4;
    localparam int NUM_HALT   = 12;
    // Two NOPs after reset and one at the end to let a last BBL pop
    localparam int NUM_INSTRUCTIONS = 3 + NUM_SINGLE + 2 * NUM_JUMPS + 2 * NUM_COND +
                                      NUM_JIN + NUM_FIM + NUM_HALT;
    localparam int CYCLE_LIMIT = 16 * NUM_INSTRUCTIONS + 64;

    logic          clock;
    logic          reset;
    logic          halt;
    nibble_t       data;
    logic          take_branch;
    logic          reg_is_zero;
    logic          sync;
    subcycle_t     cycle;
    nibble_t       inst_operand;
    logic          rom_cmd;
    logic          clear_carry;
    logic          write_carry;
    logic          clear_accumulator;
    logic          write_accumulator;
    acc_in_sel_e   acc_input_sel;
    logic          write_register;
    reg_in_sel_e   reg_input_sel;
    alu_op_e       alu_op;
    alu_in0_sel_e  alu_in0_sel;
    alu_in1_sel_e  alu_in1_sel;
    alu_cin_sel_e  alu_cin_sel;
    pc_next_sel_e  pc_next_sel;
    pc_write_e     pc_write_enable;
    pc_stack_e     pc_control;

    // Reference copies of the sequencer state
    subcycle_t     model_cycle;
    logic [7:0]    model_inst;
    logic          model_two_word;
    string         test_name;
    int unsigned   cycle_count;

    task automatic stop_on_failure();
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first failure");
    endtask

    `include "control_checks.svh"

    clock_gen u_clock (.clock, .reset);

    control_unit dut (.*);

    always @(posedge clock) begin : compare_outputs
        control_word_t actual;
        if (reset) begin
            model_cycle    = '0;
            model_inst     = 8'h00;
            model_two_word = 1'b0;
        end else if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: no end of test after %0d cycles in %s", cycle_count, test_name);
            stop_on_failure();
        end else begin
            cycle_count++;
            actual = {clear_carry, write_carry, clear_accumulator, write_accumulator,
                      acc_input_sel, write_register, reg_input_sel, alu_op, alu_in0_sel,
                      alu_in1_sel, alu_cin_sel, pc_next_sel, pc_write_enable, pc_control};
            check_subcycle(test_name, model_cycle, model_cycle != SC_LAST, cycle, sync);
            check_strobe(test_name, model_cycle != SC_ROM_CMD, rom_cmd);
            check_operand(test_name, expected_operand(model_cycle, model_inst, model_two_word),
                          inst_operand);
            check_control(test_name, expected_control(model_cycle, model_inst, model_two_word,
                          take_branch, reg_is_zero), actual);
            if (!halt) begin
                // A second word is used from the bus and leaves inst alone
                if (!model_two_word && model_cycle == SC_FETCH_HI) begin
                    model_inst[7:4] = data;
                end else if (!model_two_word && model_cycle == SC_FETCH_LO) begin
                    model_inst[3:0] = data;
                end
                if (model_cycle == SC_EXECUTE) begin
                    model_two_word = !model_two_word && starts_second_word(model_inst);
                end
                model_cycle = model_cycle + 3'd1;
            end
        end
    end

    // One system cycle of bus traffic, entered on a falling edge in subcycle 0
    task automatic run_word(input nibble_t hi, input nibble_t lo, input int halt_at,
            input int halt_len);
        int s;
        take_branch = 1'($urandom_range(0, 1));
        reg_is_zero = 1'($urandom_range(0, 1));
        for (s = 0; s < 8; s++) begin
            if (s == halt_at) begin
                halt = 1'b1;
                repeat (halt_len) begin
                    data = nibble_t'($urandom);
                    @(negedge clock);
                end
                halt = 1'b0;
            end
            if (s == SC_FETCH_HI) begin
                data = hi;
            end else if (s == SC_FETCH_LO) begin
                data = lo;
            end else begin
                data = nibble_t'($urandom);
            end
            @(negedge clock);
        end
    endtask

    task automatic issue(input logic [7:0] first, input logic [7:0] second,
            input logic with_halt);
        logic two;
        int   halt_word;
        int   halt_at;
        int   halt_len;
        two       = starts_second_word(first);
        halt_word = two ? $urandom_range(0, 1) : 0;
        halt_at   = with_halt ? $urandom_range(0, 7) : -1;
        halt_len  = $urandom_range(1, 8);
        run_word(first[7:4], first[3:0], (halt_word == 0) ? halt_at : -1, halt_len);
        if (two) begin
            run_word(second[7:4], second[3:0], (halt_word == 1) ? halt_at : -1, halt_len);
        end
    endtask

    function automatic logic [7:0] random_single_word();
        nibble_t lo;
        lo = nibble_t'($urandom);
        case ($urandom_range(0, 8))
            0: return 8'h00;
            1: return {OP_INC, lo};
            2: return {OP_ADD, lo};
            3: return {OP_SUB, lo};
            4: return {OP_LD, lo};
            5: return {OP_XCH, lo};
            6: return {OP_BBL, lo};
            7: return {OP_LDM, lo};
            default: begin
                // Accumulator group has no code 9
                lo = 4'($urandom_range(0, 11));
                return {OP_ACC_GROUP, (lo > 4'd8) ? lo + 4'd1 : lo};
            end
        endcase
    endfunction

    function automatic logic [7:0] random_instruction();
        logic [2:0] pair;
        pair = 3'($urandom);
        case ($urandom_range(0, 6))
            0: return {OP_JUN, nibble_t'($urandom)};
            1: return {OP_JMS, nibble_t'($urandom)};
            2: return {OP_JCN, nibble_t'($urandom)};
            3: return {OP_ISZ, nibble_t'($urandom)};
            4: return {OP_JIN, pair, 1'b1};
            5: return {OP_FIM, pair, 1'b0};
            default: return random_single_word();
        endcase
    endfunction

    initial begin
        int i;
        void'($urandom(32'hb6fccf92));
        halt        = 1'b0;
        data        = '0;
        take_branch = 1'b0;
        reg_is_zero = 1'b0;
        cycle_count = 0;
        test_name   = "reset";
        wait (!reset);
        issue(8'h00, 8'h00, 1'b0);
        issue(8'h00, 8'h00, 1'b0);

        test_name = "single_word";
        for (i = 0; i < NUM_SINGLE; i++) begin
            issue(random_single_word(), 8'h00, 1'b0);
        end

        test_name = "jumps";
        for (i = 0; i < NUM_JUMPS; i++) begin
            issue({OP_JUN, nibble_t'($urandom)}, 8'($urandom), 1'b0);
            issue({OP_JMS, nibble_t'($urandom)}, 8'($urandom), 1'b0);
        end

        test_name = "conditional";
        for (i = 0; i < NUM_COND; i++) begin
            issue({OP_JCN, nibble_t'($urandom)}, 8'($urandom), 1'b0);
            issue({OP_ISZ, nibble_t'($urandom)}, 8'($urandom), 1'b0);
        end

        test_name = "jin";
        for (i = 0; i < NUM_JIN; i++) begin
            issue({OP_JIN, 3'($urandom), 1'b1}, 8'h00, 1'b0);
        end

        test_name = "fim";
        for (i = 0; i < NUM_FIM; i++) begin
            issue({OP_FIM, 3'($urandom), 1'b0}, 8'($urandom), 1'b0);
        end

        test_name = "halt";
        for (i = 0; i < NUM_HALT; i++) begin
            issue(random_instruction(), 8'($urandom), 1'b1);
        end

        test_name = "flush";
        issue(8'h00, 8'h00, 1'b0);

        $display("=== PASS ===");
        $finish;
    end

endmodule
